// ==== common/ddr_nt_pkg.sv ====
`default_nettype none

package ddr_nt_pkg;

	// register file address space
	localparam int ADDR_W = 12;
	localparam logic [ADDR_W-1:0] REG_BASE_WR = 12'd1;    // regular write data starts here
	localparam logic [ADDR_W-1:0] IMM_BASE_WR = 12'd1004; // immediate write data
	localparam logic [ADDR_W-1:0] REG_BASE_RD = 12'd10;   // read data lands here
	localparam logic [ADDR_W-1:0] DUMMY_ADDR  = 12'd999;  // parked here after the last byte

	// 7 bit target address = device index + offset
	localparam logic [6:0] TGT_ADDR_OFS = 7'd8;

	// scl stall lengths for the closing patterns
	localparam logic [4:0] RESTART_STALL = 5'd7;
	localparam logic [4:0] EXIT_STALL    = 5'd13;

	// staller done is held this many extra cycles
	localparam logic [1:0] STRETCH_CNT = 2'd3;

	typedef enum logic [4:0] {
		st_idle        = 5'd0,
		st_cmd_pre     = 5'd1,  // hdr command preamble
		st_seven_zeros = 5'd2,
		st_address     = 5'd3,
		st_parity      = 5'd4,  // command or data parity
		st_ack_pre     = 5'd5,
		st_ack_wait    = 5'd6,  // target ack/nack
		st_first_byte  = 5'd7,
		st_second_byte = 5'd8,
		st_data_pre    = 5'd9,  // preamble after a byte pair
		st_abort       = 5'd10, // abort or continue bit
		st_crc_pre1    = 5'd11,
		st_crc_pre2    = 5'd12,
		st_token_crc   = 5'd13,
		st_crc_value   = 5'd14,
		st_error       = 5'd15,
		st_restart     = 5'd16,
		st_exit        = 5'd17,
		st_rw_bit      = 5'd18,
		st_dummy_byte  = 5'd19  // zero pad for odd byte counts
	} state_t;

	// tx engine modes, codes shared with the phy
	typedef enum logic [3:0] {
		tx_special_preamble = 4'd0,
		tx_serial_addr      = 4'd1,
		tx_one_pre          = 4'd2,
		tx_seven_zeros      = 4'd3,
		tx_calc_parity      = 4'd4,
		tx_zero_pre         = 4'd6,
		tx_serial_byte      = 4'd7,
		tx_token_crc        = 4'd12,
		tx_crc_value        = 4'd13,
		tx_exit_pat         = 4'd14,
		tx_restart_pat      = 4'd15
	} tx_mode_t;

	// rx engine modes
	typedef enum logic [2:0] {
		rx_pre          = 3'd0,
		rx_crc_check    = 3'd2,
		rx_byte         = 3'd3,
		rx_err          = 3'd4,
		rx_parity_check = 3'd6,
		rx_token_check  = 3'd7
	} rx_mode_t;

	// error codes reported to the register file
	typedef enum logic [3:0] {
		err_success     = 4'd0,
		err_crc         = 4'd1,
		err_parity      = 4'd2,
		err_frame       = 4'd3,
		err_nack        = 4'd5,
		err_short_read  = 4'd7,
		err_bus_aborted = 4'd9
	} err_t;

endpackage

`default_nettype wire

// ==== ddr_nt_fsm/ddr_nt_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_nt_fsm import ddr_nt_pkg::*; (
	input  wire logic       i_sys_clk,
	input  wire logic       i_sys_rst,
	input  wire logic       i_engine_en,
	input  wire logic       i_frmcnt_last,      // frame counter at last byte
	input  wire logic       i_tx_mode_done,
	input  wire logic       i_rx_mode_done,
	input  wire logic       i_rx_pre,           // sampled preamble bit
	input  wire logic       i_rx_error,
	input  wire logic       i_regf_toc,         // 0 restart, 1 exit
	input  wire logic [4:0] i_regf_dev_index,
	input  wire logic       i_regf_short_read,  // short read is an error
	input  wire logic       i_regf_wr_rd_bit,   // 0 write, 1 read
	input  wire logic       i_parity_data,      // parity state covers data
	output state_t          o_state,
	output logic            o_tx_en,
	output tx_mode_t        o_tx_mode,
	output logic            o_rx_en,
	output rx_mode_t        o_rx_mode,
	output logic            o_frmcnt_en,
	output logic            o_bitcnt_rst,
	output logic            o_regf_wr_en,
	output logic            o_regf_rd_en,
	output logic            o_regf_abort,
	output err_t            o_regf_error_type,
	output logic [7:0]      o_tx_special_data,
	output logic [4:0]      o_sclstall_no_of_cycles,
	output logic            o_stall_req,
	output logic            o_engine_done
);

	state_t     next_state;
	logic       mode_done;  // either engine finished its mode
	logic [6:0] tgt_addr;

	assign mode_done = i_tx_mode_done | i_rx_mode_done;
	assign tgt_addr  = {2'b00, i_regf_dev_index} + TGT_ADDR_OFS; // dynamic address rule

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
			o_state <= st_idle;
		else
			o_state <= next_state;
	end

	always_comb
	begin
		next_state = o_state; // hold until the phy reports done
		case (o_state)
			st_idle:
				if (i_engine_en)
					next_state = st_cmd_pre;
			st_cmd_pre:
				if (!i_engine_en)
					next_state = st_idle; // enable dropped before start
				else if (i_tx_mode_done)
					next_state = st_rw_bit;
			st_rw_bit:
				if (i_tx_mode_done)
					next_state = st_seven_zeros;
			st_seven_zeros:
				if (i_tx_mode_done)
					next_state = st_address;
			st_address:
				if (i_tx_mode_done)
					next_state = st_parity;
			st_parity:
				if (mode_done)
				begin
					if (!i_parity_data)
						next_state = st_ack_pre; // command parity done
					else if (!i_regf_wr_rd_bit)
						next_state = i_frmcnt_last ? st_crc_pre1 : st_data_pre;
					else
						next_state = i_rx_error ? st_error : st_data_pre;
				end
			st_ack_pre:
				if (i_tx_mode_done)
					next_state = st_ack_wait;
			st_ack_wait:
				if (i_rx_mode_done)
					next_state = i_rx_pre ? st_error : st_first_byte; // high pre is nack
			st_first_byte:
				if (mode_done)
					next_state = i_frmcnt_last ? st_dummy_byte : st_second_byte;
			st_second_byte, st_dummy_byte:
				if (mode_done)
					next_state = st_parity;
			st_data_pre:
				if (mode_done)
				begin
					if (!i_regf_wr_rd_bit || i_rx_pre)
						next_state = st_abort;
					else if (i_regf_short_read && !i_frmcnt_last)
						next_state = st_error; // target ended early
					else
						next_state = st_crc_pre2;
				end
			st_abort:
				if (mode_done)
				begin
					if (!i_regf_wr_rd_bit)
						next_state = i_rx_pre ? st_first_byte : st_error; // target abort
					else
						next_state = i_frmcnt_last ? st_error : st_first_byte; // we stop the read
				end
			st_crc_pre1:
				if (mode_done)
					next_state = st_crc_pre2;
			st_crc_pre2:
				if (mode_done)
					next_state = (i_regf_wr_rd_bit && !i_rx_pre) ? st_error : st_token_crc;
			st_token_crc:
				if (mode_done)
					next_state = (i_regf_wr_rd_bit && i_rx_error) ? st_error : st_crc_value;
			st_crc_value:
				if (mode_done)
				begin
					if (i_regf_wr_rd_bit && i_rx_error)
						next_state = st_error;
					else
						next_state = i_regf_toc ? st_exit : st_restart;
				end
			st_error:
				if (i_rx_mode_done)
					next_state = i_regf_toc ? st_exit : st_restart;
			st_restart, st_exit:
				if (i_tx_mode_done)
					next_state = st_idle;
			default:
				next_state = st_idle;
		endcase
	end

	always_comb
	begin
		o_tx_en                 = 1'b0;
		o_tx_mode               = tx_special_preamble;
		o_rx_en                 = 1'b0;
		o_rx_mode               = rx_pre;
		o_frmcnt_en             = 1'b1; // frame counter runs from the address on
		o_bitcnt_rst            = 1'b0;
		o_regf_wr_en            = 1'b0;
		o_regf_rd_en            = 1'b0;
		o_regf_abort            = 1'b0;
		o_regf_error_type       = err_success;
		o_tx_special_data       = 8'd0;
		o_sclstall_no_of_cycles = 5'd0;
		o_stall_req             = 1'b0;
		o_engine_done           = 1'b0;
		case (o_state)
			st_idle:
				o_frmcnt_en = 1'b0;
			st_cmd_pre:
			begin
				o_tx_en     = 1'b1;
				o_frmcnt_en = 1'b0;
			end
			st_rw_bit:
			begin
				o_tx_en     = 1'b1;
				o_tx_mode   = i_regf_wr_rd_bit ? tx_one_pre : tx_zero_pre;
				o_frmcnt_en = 1'b0;
			end
			st_seven_zeros:
			begin
				o_tx_en     = 1'b1;
				o_tx_mode   = tx_seven_zeros;
				o_frmcnt_en = 1'b0;
			end
			st_address:
			begin
				o_tx_en           = 1'b1;
				o_tx_mode         = tx_serial_addr;
				o_tx_special_data = {1'b0, tgt_addr};
			end
			st_parity:
				if (i_regf_wr_rd_bit && i_parity_data)
				begin
					// read data parity comes from the target
					o_rx_en   = 1'b1;
					o_rx_mode = rx_parity_check;
					if (i_rx_mode_done && i_rx_error)
						o_regf_error_type = err_parity;
				end
				else
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = tx_calc_parity;
				end
			st_ack_pre:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = tx_one_pre;
			end
			st_ack_wait:
			begin
				o_rx_en = 1'b1;
				if (i_rx_mode_done && i_rx_pre)
					o_regf_error_type = err_nack;
			end
			st_first_byte, st_second_byte, st_dummy_byte:
				if (!i_regf_wr_rd_bit)
				begin
					o_tx_en      = 1'b1;
					o_tx_mode    = tx_serial_byte;
					o_regf_rd_en = (o_state != st_dummy_byte); // pad byte reads nothing
				end
				else
				begin
					o_rx_en      = 1'b1;
					o_rx_mode    = rx_byte;
					o_regf_wr_en = (o_state != st_dummy_byte);
				end
			st_data_pre:
				if (!i_regf_wr_rd_bit)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = tx_one_pre;
				end
				else
				begin
					o_rx_en = 1'b1;
					if (i_rx_mode_done && !i_rx_pre && !i_frmcnt_last && i_regf_short_read)
						o_regf_error_type = err_short_read;
				end
			st_abort:
				if (i_regf_wr_rd_bit)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = i_frmcnt_last ? tx_zero_pre : tx_one_pre; // 0 stops the target
					if (i_tx_mode_done && i_frmcnt_last)
						o_regf_error_type = err_bus_aborted;
				end
				else
				begin
					o_rx_en = 1'b1;
					if (i_rx_mode_done && !i_rx_pre)
					begin
						o_regf_abort      = 1'b1;
						o_regf_error_type = err_bus_aborted;
					end
				end
			st_crc_pre1:
			begin
				o_tx_en   = 1'b1;
				o_tx_mode = tx_zero_pre;
			end
			st_crc_pre2:
				if (!i_regf_wr_rd_bit)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = tx_one_pre;
				end
				else
				begin
					o_rx_en = 1'b1;
					if (i_rx_mode_done && !i_rx_pre)
						o_regf_error_type = err_frame; // 00 preamble before crc
				end
			st_token_crc:
				if (!i_regf_wr_rd_bit)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = tx_token_crc;
				end
				else
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = rx_token_check;
					if (i_rx_mode_done && i_rx_error)
						o_regf_error_type = err_frame;
				end
			st_crc_value:
				if (!i_regf_wr_rd_bit)
				begin
					o_tx_en   = 1'b1;
					o_tx_mode = tx_crc_value;
				end
				else
				begin
					o_rx_en   = 1'b1;
					o_rx_mode = rx_crc_check;
					if (i_rx_mode_done && i_rx_error)
						o_regf_error_type = err_crc;
				end
			st_error:
			begin
				o_rx_en      = 1'b1;
				o_rx_mode    = rx_err;
				o_bitcnt_rst = 1'b1;
			end
			st_restart:
			begin
				o_tx_en                 = 1'b1;
				o_tx_mode               = tx_restart_pat;
				o_sclstall_no_of_cycles = RESTART_STALL;
				o_stall_req             = 1'b1;
			end
			st_exit:
			begin
				o_tx_en                 = 1'b1;
				o_tx_mode               = tx_exit_pat;
				o_sclstall_no_of_cycles = EXIT_STALL;
				o_stall_req             = 1'b1;
				o_engine_done           = i_tx_mode_done; // transfer closed
			end
			default:
				o_frmcnt_en = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/ddr_nt_addr.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_nt_addr import ddr_nt_pkg::*; (
	input  wire logic         i_sys_clk,
	input  wire logic         i_sys_rst,
	input  wire state_t       i_state,
	input  wire logic         i_tx_mode_done,
	input  wire logic         i_rx_mode_done,
	input  wire logic         i_frmcnt_last,
	input  wire logic         i_regf_wr_rd_bit,
	input  wire logic         i_regf_cmd_attr0,  // immediate transfer
	output logic [ADDR_W-1:0] o_regf_addr,
	output logic              o_parity_data      // next parity is over data
);

	logic [ADDR_W-1:0] base_addr;
	logic [ADDR_W-1:0] step_addr;
	logic [ADDR_W-1:0] resume_addr; // address past the second byte of a pair
	logic              mode_done;
	logic              byte_state;

	assign mode_done  = i_tx_mode_done | i_rx_mode_done;
	assign byte_state = (i_state == st_first_byte) || (i_state == st_second_byte);

	// base depends on direction and immediate attribute
	assign base_addr = i_regf_wr_rd_bit ? REG_BASE_RD :
	                   i_regf_cmd_attr0 ? IMM_BASE_WR : REG_BASE_WR;
	assign step_addr = i_frmcnt_last ? DUMMY_ADDR : o_regf_addr + ADDR_W'(1); // park after last

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			o_regf_addr   <= '0;
			o_parity_data <= 1'b0;
		end
		else
		begin
			if (i_state == st_ack_wait && i_rx_mode_done)
				o_regf_addr <= base_addr;     // ack accepted
			else if (byte_state && mode_done)
				o_regf_addr <= step_addr;
			else if (i_state == st_abort && mode_done)
				o_regf_addr <= resume_addr;   // continue with the next pair
			// flag frozen while the parity bits go out
			if (i_state != st_parity)
				o_parity_data <= (i_state == st_second_byte) || (i_state == st_dummy_byte);
		end
	end

	always_ff @(posedge i_sys_clk)
	begin
		if (i_state == st_second_byte && mode_done)
			resume_addr <= step_addr;
	end

endmodule

`default_nettype wire

// ==== hdl/ddr_nt_stall.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_nt_stall import ddr_nt_pkg::*; (
	input  wire logic i_sys_clk,
	input  wire logic i_sys_rst,
	input  wire logic i_staller_done,  // one cycle pulse from the staller
	input  wire logic i_stall_req,     // restart or exit pattern active
	input  wire logic i_tx_mode_done,
	output logic      o_sclstall_en
);

	logic [1:0] stretch_cnt;
	logic       done_stretch; // staller done held over several cycles

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			stretch_cnt  <= 2'd0;
			done_stretch <= 1'b0;
		end
		else if (i_staller_done)
		begin
			stretch_cnt  <= STRETCH_CNT; // restart the window
			done_stretch <= 1'b1;
		end
		else if (stretch_cnt != 2'd0)
		begin
			stretch_cnt  <= stretch_cnt - 2'd1;
			done_stretch <= 1'b1;
		end
		else
			done_stretch <= 1'b0;
	end

	// no new stall right after one finished or once the pattern is out
	assign o_sclstall_en = i_stall_req & ~done_stretch & ~i_tx_mode_done;

endmodule

`default_nettype wire

// ==== hdl/ddr_nt.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_nt import ddr_nt_pkg::*; (
	input  wire logic         i_sys_clk,
	input  wire logic         i_sys_rst,
	input  wire logic         i_engine_en,
	input  wire logic         i_frmcnt_last,
	input  wire logic         i_tx_mode_done,
	input  wire logic         i_rx_mode_done,
	input  wire logic         i_rx_pre,
	input  wire logic         i_rx_error,
	input  wire logic         i_staller_done,
	input  wire logic         i_regf_toc,
	input  wire logic [4:0]   i_regf_dev_index,
	input  wire logic         i_regf_short_read,
	input  wire logic         i_regf_wr_rd_bit,
	input  wire logic [2:0]   i_regf_cmd_attr,   // bit 0 marks immediate data
	output logic              o_tx_en,
	output tx_mode_t          o_tx_mode,
	output logic              o_rx_en,
	output rx_mode_t          o_rx_mode,
	output logic              o_frmcnt_en,
	output logic              o_bitcnt_rst,
	output logic              o_regf_wr_en,
	output logic              o_regf_rd_en,
	output logic [ADDR_W-1:0] o_regf_addr,
	output logic [4:0]        o_sclstall_no_of_cycles,
	output logic              o_sclstall_en,
	output logic              o_engine_done,
	output logic [7:0]        o_tx_special_data,
	output logic              o_regf_abort,
	output err_t              o_regf_error_type
);

	state_t state;       // sequencer state, watched by the address counter
	logic   parity_data;
	logic   stall_req;

	ddr_nt_fsm u_fsm (
		.i_sys_clk               (i_sys_clk),
		.i_sys_rst               (i_sys_rst),
		.i_engine_en             (i_engine_en),
		.i_frmcnt_last           (i_frmcnt_last),
		.i_tx_mode_done          (i_tx_mode_done),
		.i_rx_mode_done          (i_rx_mode_done),
		.i_rx_pre                (i_rx_pre),
		.i_rx_error              (i_rx_error),
		.i_regf_toc              (i_regf_toc),
		.i_regf_dev_index        (i_regf_dev_index),
		.i_regf_short_read       (i_regf_short_read),
		.i_regf_wr_rd_bit        (i_regf_wr_rd_bit),
		.i_parity_data           (parity_data),
		.o_state                 (state),
		.o_tx_en                 (o_tx_en),
		.o_tx_mode               (o_tx_mode),
		.o_rx_en                 (o_rx_en),
		.o_rx_mode               (o_rx_mode),
		.o_frmcnt_en             (o_frmcnt_en),
		.o_bitcnt_rst            (o_bitcnt_rst),
		.o_regf_wr_en            (o_regf_wr_en),
		.o_regf_rd_en            (o_regf_rd_en),
		.o_regf_abort            (o_regf_abort),
		.o_regf_error_type       (o_regf_error_type),
		.o_tx_special_data       (o_tx_special_data),
		.o_sclstall_no_of_cycles (o_sclstall_no_of_cycles),
		.o_stall_req             (stall_req),
		.o_engine_done           (o_engine_done)
	);

	ddr_nt_addr u_addr (
		.i_sys_clk        (i_sys_clk),
		.i_sys_rst        (i_sys_rst),
		.i_state          (state),
		.i_tx_mode_done   (i_tx_mode_done),
		.i_rx_mode_done   (i_rx_mode_done),
		.i_frmcnt_last    (i_frmcnt_last),
		.i_regf_wr_rd_bit (i_regf_wr_rd_bit),
		.i_regf_cmd_attr0 (i_regf_cmd_attr[0]),
		.o_regf_addr      (o_regf_addr),
		.o_parity_data    (parity_data)
	);

	ddr_nt_stall u_stall (
		.i_sys_clk      (i_sys_clk),
		.i_sys_rst      (i_sys_rst),
		.i_staller_done (i_staller_done),
		.i_stall_req    (stall_req),
		.i_tx_mode_done (i_tx_mode_done),
		.o_sclstall_en  (o_sclstall_en)
	);

endmodule

`default_nettype wire

// ==== tb/ddr_nt_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module ddr_nt_assert import ddr_nt_pkg::*; (
	input wire logic        i_sys_clk,
	input wire logic        i_sys_rst,
	input wire logic        i_engine_en,
	input wire logic        i_frmcnt_last,
	input wire logic        i_tx_mode_done,
	input wire logic        i_rx_mode_done,
	input wire logic        i_rx_pre,
	input wire logic        i_staller_done,
	input wire logic        i_regf_wr_rd_bit,
	input wire logic [4:0]  i_regf_dev_index,
	input wire logic [2:0]  i_regf_cmd_attr,
	input wire logic        o_tx_en,
	input wire tx_mode_t    o_tx_mode,
	input wire logic        o_rx_en,
	input wire rx_mode_t    o_rx_mode,
	input wire logic        o_frmcnt_en,
	input wire logic        o_bitcnt_rst,
	input wire logic        o_regf_wr_en,
	input wire logic        o_regf_rd_en,
	input wire logic [11:0] o_regf_addr,
	input wire logic [4:0]  o_sclstall_no_of_cycles,
	input wire logic        o_sclstall_en,
	input wire logic        o_engine_done,
	input wire logic [7:0]  o_tx_special_data,
	input wire logic        o_regf_abort,
	input wire err_t        o_regf_error_type
);

	int          fail_cnt;   // failed assertions so far
	logic        started;    // engine enable seen since reset
	logic        data_seen;  // a data strobe was raised in this transfer
	logic [11:0] base;
	logic [11:0] exp_step;   // address expected after a byte done
	logic        strb;
	logic        mode_done;
	logic        closing;

	initial fail_cnt = 0;

	assign strb      = o_regf_rd_en | o_regf_wr_en;
	assign mode_done = i_tx_mode_done | i_rx_mode_done;
	assign closing   = o_tx_en && (o_tx_mode == tx_restart_pat || o_tx_mode == tx_exit_pat);

	// read 10, immediate write 1004, regular write 1
	assign base = i_regf_wr_rd_bit ? 12'd10 : (i_regf_cmd_attr[0] ? 12'd1004 : 12'd1);

	always_ff @(posedge i_sys_clk or negedge i_sys_rst)
	begin
		if (!i_sys_rst)
		begin
			started   <= 1'b0;
			data_seen <= 1'b0;
			exp_step  <= 12'd0;
		end
		else
		begin
			if (i_engine_en)
				started <= 1'b1;
			if (closing)
				data_seen <= 1'b0; // next transfer starts fresh
			else if (strb)
				data_seen <= 1'b1;
			exp_step <= i_frmcnt_last ? 12'd999 : o_regf_addr + 12'd1;
		end
	end

	a_reset_quiet: assert property (@(posedge i_sys_clk)
		!started |-> !(o_tx_en || o_rx_en || o_regf_wr_en || o_regf_rd_en ||
		               o_engine_done || o_sclstall_en || o_regf_abort))
	else
	begin
		$error("outputs were active before the engine was enabled");
		fail_cnt++;
	end

	a_addr_byte: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == tx_serial_addr) |->
			o_tx_special_data == {3'b000, i_regf_dev_index} + 8'd8)
	else
	begin
		$error("error addr_byte expected %0d actual %0d",
			{3'b000, $sampled(i_regf_dev_index)} + 8'd8, $sampled(o_tx_special_data));
		fail_cnt++;
	end

	a_addr_base: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		($rose(strb) && !data_seen && !mode_done) |=> o_regf_addr == base)
	else
	begin
		$error("error addr_base expected %0d actual %0d",
			$sampled(base), $sampled(o_regf_addr));
		fail_cnt++;
	end

	a_addr_step: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(strb && mode_done) |=> o_regf_addr == exp_step)
	else
	begin
		$error("error addr_step expected %0d actual %0d",
			$sampled(exp_step), $sampled(o_regf_addr));
		fail_cnt++;
	end

	// only rx preamble of a write before any data is the ack
	a_nack: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(!i_regf_wr_rd_bit && o_rx_en && o_rx_mode == rx_pre && !data_seen &&
		 i_rx_mode_done && i_rx_pre) |-> o_regf_error_type == err_nack)
	else
	begin
		$error("error nack expected %0d actual %0d", err_nack, $sampled(o_regf_error_type));
		fail_cnt++;
	end

	// frame counter idles until the address goes out
	a_frmcnt_off: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(!(o_tx_en || o_rx_en) || (o_tx_en && o_tx_mode == tx_seven_zeros)) |-> !o_frmcnt_en)
	else
	begin
		$error("error frmcnt_off expected 0 actual %0d", $sampled(o_frmcnt_en));
		fail_cnt++;
	end

	a_frmcnt_on: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		((o_tx_en && o_tx_mode == tx_serial_addr) || strb) |-> o_frmcnt_en)
	else
	begin
		$error("error frmcnt_on expected 1 actual %0d", $sampled(o_frmcnt_en));
		fail_cnt++;
	end

	// bit counter held in reset while the error pattern is received
	a_bitcnt_rst: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_bitcnt_rst == (o_rx_en && o_rx_mode == rx_err))
	else
	begin
		$error("error bitcnt_rst expected %0d actual %0d",
			$sampled(o_rx_en && o_rx_mode == rx_err), $sampled(o_bitcnt_rst));
		fail_cnt++;
	end

	a_restart_len: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == tx_restart_pat) |-> o_sclstall_no_of_cycles == 5'd7)
	else
	begin
		$error("error restart_len expected 7 actual %0d", $sampled(o_sclstall_no_of_cycles));
		fail_cnt++;
	end

	a_exit_len: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == tx_exit_pat) |-> o_sclstall_no_of_cycles == 5'd13)
	else
	begin
		$error("error exit_len expected 13 actual %0d", $sampled(o_sclstall_no_of_cycles));
		fail_cnt++;
	end

	a_exit_done: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		(o_tx_en && o_tx_mode == tx_exit_pat) |-> o_engine_done == i_tx_mode_done)
	else
	begin
		$error("error exit_done expected %0d actual %0d",
			$sampled(i_tx_mode_done), $sampled(o_engine_done));
		fail_cnt++;
	end

	a_stall_window: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		o_sclstall_en |-> closing)
	else
	begin
		$error("scl stall was enabled outside a restart or exit pattern");
		fail_cnt++;
	end

	a_stall_mask: assert property (@(posedge i_sys_clk) disable iff (!i_sys_rst)
		i_staller_done |=> !o_sclstall_en [*4])
	else
	begin
		$error("scl stall came back within 4 cycles of staller done");
		fail_cnt++;
	end

endmodule

`default_nettype wire

// ==== tb/tb_ddr_nt.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ddr_nt import ddr_nt_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 4000; // four transfers, ~60 states, 4 cycles each, margin

	logic        i_sys_clk;
	logic        i_sys_rst;
	logic        i_engine_en;
	logic        i_frmcnt_last;
	logic        i_tx_mode_done;
	logic        i_rx_mode_done;
	logic        i_rx_pre;
	logic        i_rx_error;
	logic        i_staller_done;
	logic        i_regf_toc;
	logic [4:0]  i_regf_dev_index;
	logic        i_regf_short_read;
	logic        i_regf_wr_rd_bit;
	logic [2:0]  i_regf_cmd_attr;
	logic        o_tx_en;
	tx_mode_t    o_tx_mode;
	logic        o_rx_en;
	rx_mode_t    o_rx_mode;
	logic        o_frmcnt_en;
	logic        o_bitcnt_rst;
	logic        o_regf_wr_en;
	logic        o_regf_rd_en;
	logic [11:0] o_regf_addr;
	logic [4:0]  o_sclstall_no_of_cycles;
	logic        o_sclstall_en;
	logic        o_engine_done;
	logic [7:0]  o_tx_special_data;
	logic        o_regf_abort;
	err_t        o_regf_error_type;

	integer seed = 32'h76af;
	int     cycles = 0;
	int     dly;        // cycles left before the phy answers
	int     stall_dly;  // cycles left before the staller answers
	bit     pulsed;     // done sent last cycle, wait for the new state
	int     nbytes;
	int     bytes_done;
	int     pre_cnt;    // rx preambles answered after the data of a read
	bit     data_seen;
	bit     nack_mode;
	bit     xfer_done;

	ddr_nt u_ddr_nt (.*);

	bind ddr_nt ddr_nt_assert u_chk (.*);

	always #10 i_sys_clk = ~i_sys_clk;

	function automatic int draw_delay();
		int r;
		r = $random(seed);
		return 1 + (r & 3);
	endfunction

	// phy and target answer to the current mode
	task automatic answer_mode();
		if (o_tx_en)
		begin
			i_tx_mode_done = 1'b1;
			if (o_tx_mode == tx_restart_pat || o_tx_mode == tx_exit_pat)
				xfer_done = 1'b1;
		end
		else
		begin
			i_rx_mode_done = 1'b1;
			i_rx_pre       = 1'b0;
			if (nack_mode)
				i_rx_pre = 1'b1; // target refuses
			else if (!i_regf_wr_rd_bit)
				i_rx_pre = data_seen; // ack first, then continue at abort
			else if (o_rx_mode == rx_pre && data_seen)
			begin
				i_rx_pre = (pre_cnt > 0); // end of data, then crc preamble
				pre_cnt++;
			end
		end
		if (o_regf_rd_en || o_regf_wr_en)
		begin
			data_seen = 1'b1;
			bytes_done++;
		end
	endtask

	always @(negedge i_sys_clk)
	begin
		i_tx_mode_done = 1'b0;
		i_rx_mode_done = 1'b0;
		i_staller_done = 1'b0;
		// last byte in flight, or all bytes gone
		i_frmcnt_last  = ((o_regf_rd_en || o_regf_wr_en) && bytes_done == nbytes - 1) ||
		                 (bytes_done >= nbytes);
		if (!i_sys_rst)
		begin
			dly       = 0;
			stall_dly = 0;
			pulsed    = 1'b0;
		end
		else
		begin
			if (pulsed)
				pulsed = 1'b0;
			else if (o_tx_en || o_rx_en)
			begin
				if (dly == 0)
					dly = draw_delay();
				else
				begin
					dly--;
					if (dly == 0)
					begin
						answer_mode();
						pulsed = 1'b1;
					end
				end
			end
			// staller answers a stall request
			if (stall_dly == 0)
			begin
				if (o_sclstall_en)
					stall_dly = draw_delay();
			end
			else
			begin
				stall_dly--;
				if (stall_dly == 0)
					i_staller_done = 1'b1;
			end
		end
	end

	// watchdog and first assertion failure
	always @(posedge i_sys_clk)
	begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES)
		begin
			$display("the run timed out after %0d cycles", cycles);
			$display("Checks failed");
			$fatal(1, "timeout");
		end
		else if (u_ddr_nt.u_chk.fail_cnt != 0)
		begin
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

	task automatic run_transfer(input logic rd, input logic imm, input logic toc,
	                            input int n, input bit nack, input logic [4:0] idx);
		@(negedge i_sys_clk);
		i_regf_wr_rd_bit = rd;
		i_regf_cmd_attr  = {2'b00, imm};
		i_regf_toc       = toc;
		i_regf_dev_index = idx;
		nbytes           = n;
		nack_mode        = nack;
		bytes_done       = 0;
		pre_cnt          = 0;
		data_seen        = 1'b0;
		xfer_done        = 1'b0;
		i_engine_en      = 1'b1;
		while (!xfer_done)
			@(posedge i_sys_clk);
		@(negedge i_sys_clk);
		i_engine_en = 1'b0; // drop before idle can restart
		repeat (3) @(posedge i_sys_clk);
	endtask

	initial
	begin
		i_sys_clk         = 1'b0;
		i_sys_rst         = 1'b0;
		i_engine_en       = 1'b0;
		i_frmcnt_last     = 1'b0;
		i_tx_mode_done    = 1'b0;
		i_rx_mode_done    = 1'b0;
		i_rx_pre          = 1'b0;
		i_rx_error        = 1'b0;
		i_staller_done    = 1'b0;
		i_regf_toc        = 1'b1;
		i_regf_dev_index  = 5'd0;
		i_regf_short_read = 1'b0;
		i_regf_wr_rd_bit  = 1'b0;
		i_regf_cmd_attr   = 3'd0;
		nbytes            = 4;
		bytes_done        = 0;
		repeat (8) @(posedge i_sys_clk);
		@(negedge i_sys_clk);
		i_sys_rst = 1'b1;
		repeat (4) @(posedge i_sys_clk); // quiet idle after reset

		run_transfer(1'b0, 1'b0, 1'b1, 4, 1'b0, 5'd5);  // regular write, exit
		run_transfer(1'b0, 1'b1, 1'b0, 3, 1'b0, 5'd17); // immediate write, restart
		run_transfer(1'b1, 1'b0, 1'b1, 2, 1'b0, 5'd2);  // read, exit
		run_transfer(1'b0, 1'b0, 1'b1, 4, 1'b1, 5'd30); // write refused by target

		repeat (5) @(posedge i_sys_clk);
		if (u_ddr_nt.u_chk.fail_cnt == 0)
		begin
			$display("All checks passed");
			$finish;
		end
		else
		begin
			$display("Checks failed");
			$fatal(1, "assertion failure");
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
common/ddr_nt_pkg.sv
ddr_nt_fsm/ddr_nt_fsm.sv
hdl/ddr_nt_addr.sv
hdl/ddr_nt_stall.sv
hdl/ddr_nt.sv
tb/ddr_nt_assert.sv
tb/tb_ddr_nt.sv

// ==== Makefile ====
# Verilator flow for the ddr_nt sequencer

VERILATOR ?= verilator
TOP       ?= tb_ddr_nt
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Checks failed
PASS_MSG  ?= All checks passed

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o sim_$(TOP)
	./$(BUILD_DIR)/sim_$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
